// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////

// Data and address word
`define WORD_W 32

// Register file index
`define REG_IDX_W 5

////////////////////////////////////////////////////////////////////////
// Data memory
////////////////////////////////////////////////////////////////////////

// Number of words, index width follows from it
`define DRAM_DEPTH 2048

`endif

// ==== cpu_types_pkg.sv ====
`include "mem_config.svh"

package cpu_types_pkg;

	////////////////////////////////////////////////////////////////////////
	// Widths derived from the configuration header
	////////////////////////////////////////////////////////////////////////

	localparam int WORD_W     = `WORD_W;
	localparam int REG_IDX_W  = `REG_IDX_W;
	localparam int DRAM_IDX_W = $clog2(`DRAM_DEPTH);

	////////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////////

	// Data word, also used for addresses and the PC
	typedef logic [WORD_W-1:0] word_t;

	// Register file index
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Data RAM word index, low bits of the ALU result
	typedef logic [DRAM_IDX_W-1:0] dram_idx_t;

endpackage

// ==== mem_ctrl_pkg.sv ====
package mem_ctrl_pkg;

	import cpu_types_pkg::*;

	////////////////////////////////////////////////////////////////////////
	// Control bundles from the decoder
	////////////////////////////////////////////////////////////////////////

	// Memory stage control, mem_write sits at bit 0 and branch_ne at bit 8
	typedef struct packed {
		logic branch_ne;
		logic store_byte;
		logic store_half;
		logic load_byte;
		logic load_half;
		logic load_unsigned;
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	// Writeback stage control
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// Size of a load, half wins over byte
	typedef enum logic [1:0] {
		LOAD_WORD = 2'd0,
		LOAD_HALF = 2'd1,
		LOAD_BYTE = 2'd2
	} load_mode_t;

	////////////////////////////////////////////////////////////////////////
	// MEM/WB pipeline register contents
	////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		wb_ctrl_t wb;
		word_t    read_data;
		word_t    alu_result;
		reg_idx_t dest_reg;
	} mem_wb_t;

endpackage

// ==== data_ram.sv ====
`include "mem_config.svh"

module data_ram
	import cpu_types_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  dram_idx_t idx,
	input  word_t     wdata,
	input  logic      we,
	input  logic      re,
	output word_t     rdata
);

	// Word array, contents survive reset
	word_t mem [`DRAM_DEPTH];

	////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[idx] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Registered read port
	////////////////////////////////////////////////////////////////////////

	// Holds the last word read while re is low
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rdata <= '0;
		end
		else if (re)
		begin
			// Old contents on a same-cycle write
			rdata <= mem[idx];
		end
	end

endmodule

// ==== mem_access.sv ====
module mem_access
	import cpu_types_pkg::*;
	import mem_ctrl_pkg::*;
(
	input  word_t     alu_result,
	input  word_t     store_data,
	input  mem_ctrl_t mem_ctrl,
	input  logic      zero,
	input  word_t     pc_branch,
	input  logic      clk,
	input  logic      arst_n,
	output logic      pc_src,
	output word_t     pc_branch_out,
	output word_t     ram_word
);

	dram_idx_t ram_idx;
	word_t     store_word;

	////////////////////////////////////////////////////////////////////////
	// Store resizing
	////////////////////////////////////////////////////////////////////////

	// Word addressed RAM, so narrow stores fill the whole word
	always_comb
	begin
		if (mem_ctrl.store_half)
		begin
			store_word = {{($bits(word_t) - 16){store_data[15]}}, store_data[15:0]};
		end
		else if (mem_ctrl.store_byte)
		begin
			store_word = {{($bits(word_t) - 8){store_data[7]}}, store_data[7:0]};
		end
		else
		begin
			store_word = store_data;
		end
	end

	// No byte offset, low bits pick the word
	assign ram_idx = alu_result[$bits(dram_idx_t)-1:0];

	////////////////////////////////////////////////////////////////////////
	// Data RAM
	////////////////////////////////////////////////////////////////////////

	data_ram u_data_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.idx    (ram_idx),
		.wdata  (store_word),
		.we     (mem_ctrl.mem_write),
		.re     (mem_ctrl.mem_read),
		.rdata  (ram_word)
	);

	////////////////////////////////////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////////////////////////////////////

	// Taken on zero for beq, on not zero for bne
	always_comb
	begin
		if (mem_ctrl.branch_ne)
		begin
			pc_src = mem_ctrl.branch & ~zero;
		end
		else
		begin
			pc_src = mem_ctrl.branch & zero;
		end
	end

	assign pc_branch_out = pc_branch;

endmodule

// ==== mem_wb_stage.sv ====
module mem_wb_stage
	import cpu_types_pkg::*;
	import mem_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  wb_ctrl_t  wb_ctrl,
	input  word_t     alu_result,
	input  reg_idx_t  dest_reg,
	input  mem_ctrl_t mem_ctrl,
	input  word_t     ram_word,
	output mem_wb_t   mem_wb
);

	load_mode_t load_mode;
	load_mode_t load_mode_q;
	logic       unsigned_q;
	wb_ctrl_t   wb_q;
	word_t      alu_result_q;
	reg_idx_t   dest_reg_q;
	logic       half_fill;
	logic       byte_fill;
	word_t      load_word;

	// Half has priority when both flags are set
	always_comb
	begin
		if (mem_ctrl.load_half)
		begin
			load_mode = LOAD_HALF;
		end
		else if (mem_ctrl.load_byte)
		begin
			load_mode = LOAD_BYTE;
		end
		else
		begin
			load_mode = LOAD_WORD;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb_q         <= '0;
			alu_result_q <= '0;
			dest_reg_q   <= '0;
			load_mode_q  <= LOAD_WORD;
			unsigned_q   <= 1'b0;
		end
		else
		begin
			wb_q         <= wb_ctrl;
			alu_result_q <= alu_result;
			dest_reg_q   <= dest_reg;
			load_mode_q  <= load_mode;
			unsigned_q   <= mem_ctrl.load_unsigned;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Load extension
	////////////////////////////////////////////////////////////////////////

	// RAM word is already registered, so this lines up with the sideband
	assign half_fill = ~unsigned_q & ram_word[15];
	assign byte_fill = ~unsigned_q & ram_word[7];

	always_comb
	begin
		case (load_mode_q)
			LOAD_HALF: load_word = {{($bits(word_t) - 16){half_fill}}, ram_word[15:0]};
			LOAD_BYTE: load_word = {{($bits(word_t) - 8){byte_fill}}, ram_word[7:0]};
			default:   load_word = ram_word;
		endcase
	end

	assign mem_wb = '{
		wb:         wb_q,
		read_data:  load_word,
		alu_result: alu_result_q,
		dest_reg:   dest_reg_q
	};

endmodule

// ==== mem_stage_top.sv ====
module mem_stage_top
	import cpu_types_pkg::*;
	import mem_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,

	// From the execute stage
	input  word_t     alu_result,
	input  word_t     store_data,
	input  mem_ctrl_t mem_ctrl,
	input  wb_ctrl_t  wb_ctrl,
	input  reg_idx_t  dest_reg,
	input  logic      zero,
	input  word_t     pc_branch,

	// Back to fetch
	output logic      pc_src,
	output word_t     pc_branch_out,

	// To the writeback stage
	output mem_wb_t   mem_wb
);

	////////////////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////////////////

	// Registered RAM read word
	word_t ram_word;

	////////////////////////////////////////////////////////////////////////
	// Memory access and branch
	////////////////////////////////////////////////////////////////////////

	mem_access u_mem_access (
		.alu_result    (alu_result),
		.store_data    (store_data),
		.mem_ctrl      (mem_ctrl),
		.zero          (zero),
		.pc_branch     (pc_branch),
		.clk           (clk),
		.arst_n        (arst_n),
		.pc_src        (pc_src),
		.pc_branch_out (pc_branch_out),
		.ram_word      (ram_word)
	);

	////////////////////////////////////////////////////////////////////////
	// MEM/WB register and load extension
	////////////////////////////////////////////////////////////////////////

	mem_wb_stage u_mem_wb_stage (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_ctrl    (wb_ctrl),
		.alu_result (alu_result),
		.dest_reg   (dest_reg),
		.mem_ctrl   (mem_ctrl),
		.ram_word   (ram_word),
		.mem_wb     (mem_wb)
	);

endmodule

// ==== tb_mem_stage.sv ====
`include "mem_config.svh"

module tb_mem_stage
	import cpu_types_pkg::*;
	import mem_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF       = 50;
	localparam int RESET_CYCLES   = 10;
	localparam int IDX_W          = $bits(dram_idx_t);
	localparam int UPPER_W        = $bits(word_t) - IDX_W;
	localparam int PAIR_ROUNDS    = 100;
	localparam int HOLD_ROUNDS    = 20;
	localparam int RANDOM_OPS     = 1300;
	// Reset, paired ops, hold ops and random ops plus margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 6 * PAIR_ROUNDS + 5 * HOLD_ROUNDS
		+ RANDOM_OPS + 190;

	logic      clk = 1'b0;
	logic      arst_n;
	word_t     alu_result;
	word_t     store_data;
	mem_ctrl_t mem_ctrl;
	wb_ctrl_t  wb_ctrl;
	reg_idx_t  dest_reg;
	logic      zero;
	word_t     pc_branch;
	logic      pc_src;
	word_t     pc_branch_out;
	mem_wb_t   mem_wb;

	logic [31:0] lfsr = 32'h2825;
	int          cycles = 0;

	// Reference model state
	word_t       ref_mem [`DRAM_DEPTH];
	word_t       ref_rd = '0;
	mem_wb_t     exp_wb = '0;

	// Indices that hold a known word and may be loaded
	bit          stored_flag [`DRAM_DEPTH];
	dram_idx_t   stored_idx [$];

	mem_stage_top uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.mem_ctrl      (mem_ctrl),
		.wb_ctrl       (wb_ctrl),
		.dest_reg      (dest_reg),
		.zero          (zero),
		.pc_branch     (pc_branch),
		.pc_src        (pc_src),
		.pc_branch_out (pc_branch_out),
		.mem_wb        (mem_wb)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t random_word();
		return rand_bits($bits(word_t));
	endfunction

	function automatic dram_idx_t random_idx();
		logic [31:0] r;
		r = rand_bits(IDX_W);
		return r[IDX_W-1:0];
	endfunction

	function automatic mem_ctrl_t random_ctrl();
		logic [31:0] r;
		r = rand_bits($bits(mem_ctrl_t));
		return r[$bits(mem_ctrl_t)-1:0];
	endfunction

	// Load with random size and sign flags
	function automatic mem_ctrl_t load_ctrl();
		mem_ctrl_t   c;
		logic [31:0] r;
		r = rand_bits(3);
		c = '0;
		c.mem_read = 1'b1;
		c.load_half = r[0];
		c.load_byte = r[1];
		c.load_unsigned = r[2];
		return c;
	endfunction

	function automatic dram_idx_t pick_stored();
		int k;
		k = int'(rand_bits(16)) % stored_idx.size();
		return stored_idx[k];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference functions
	//////////////////////////////////////////////////////////////////////

	// Narrow stores keep the sign-extended low part and half wins over byte
	function automatic word_t stored_word(input word_t data, input mem_ctrl_t c);
		if (c.store_half)
		begin
			return {{16{data[15]}}, data[15:0]};
		end
		else if (c.store_byte)
		begin
			return {{24{data[7]}}, data[7:0]};
		end
		else
		begin
			return data;
		end
	endfunction

	function automatic word_t expected_load(input word_t w, input mem_ctrl_t c);
		word_t ext;
		if (c.load_half)
		begin
			ext = c.load_unsigned ? {16'h0000, w[15:0]} : {{16{w[15]}}, w[15:0]};
		end
		else if (c.load_byte)
		begin
			ext = c.load_unsigned ? {24'h000000, w[7:0]} : {{24{w[7]}}, w[7:0]};
		end
		else
		begin
			ext = w;
		end
		return ext;
	endfunction

	function automatic logic expected_branch(input mem_ctrl_t c, input logic z);
		return c.branch && (c.branch_ne ? !z : z);
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// One operation per cycle with random sideband fields
	task automatic issue_op(input mem_ctrl_t c, input dram_idx_t idx, input word_t data);
		logic [31:0] upper;
		logic [31:0] r;
		word_t       target;
		upper = rand_bits(UPPER_W);
		r = rand_bits(8);
		target = random_word();
		if (c.mem_write && !stored_flag[idx])
		begin
			stored_flag[idx] = 1'b1;
			stored_idx.push_back(idx);
		end
		@(posedge clk);
		alu_result <= {upper[UPPER_W-1:0], idx};
		store_data <= data;
		mem_ctrl   <= c;
		wb_ctrl    <= r[1:0];
		dest_reg   <= r[6:2];
		zero       <= r[7];
		pc_branch  <= target;
	endtask

	// Store then load back for word, half and byte stores
	task automatic store_load_pairs();
		mem_ctrl_t c;
		dram_idx_t idx;
		for (int i = 0; i < PAIR_ROUNDS; i++)
		begin
			idx = random_idx();
			c = '0;
			c.mem_write = 1'b1;
			issue_op(c, idx, random_word());
			c = '0;
			c.mem_read = 1'b1;
			issue_op(c, idx, random_word());

			idx = random_idx();
			c = random_ctrl();
			c.mem_write = 1'b1;
			c.mem_read = 1'b0;
			c.store_half = 1'b1;
			issue_op(c, idx, random_word());
			issue_op(load_ctrl(), idx, random_word());

			idx = random_idx();
			c = '0;
			c.mem_write = 1'b1;
			c.store_byte = 1'b1;
			issue_op(c, idx, random_word());
			issue_op(load_ctrl(), idx, random_word());
		end
	endtask

	// Load followed by idle cycles that only change the load mode
	task automatic hold_after_load();
		mem_ctrl_t c;
		for (int i = 0; i < HOLD_ROUNDS; i++)
		begin
			issue_op(load_ctrl(), pick_stored(), random_word());
			repeat (4)
			begin
				c = random_ctrl();
				c.mem_read = 1'b0;
				c.mem_write = 1'b0;
				issue_op(c, random_idx(), random_word());
			end
		end
	endtask

	task automatic random_ops();
		mem_ctrl_t c;
		dram_idx_t idx;
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			c = random_ctrl();
			if (c.mem_read)
			begin
				idx = pick_stored();
			end
			else
			begin
				idx = random_idx();
			end
			issue_op(c, idx, random_word());
		end
	endtask

	initial
	begin
		mem_ctrl_t reset_ctrl;
		// All ones during reset except the RAM strobes
		reset_ctrl = '1;
		reset_ctrl.mem_read = 1'b0;
		reset_ctrl.mem_write = 1'b0;
		arst_n     <= 1'b0;
		alu_result <= '1;
		store_data <= '1;
		mem_ctrl   <= reset_ctrl;
		wb_ctrl    <= '1;
		dest_reg   <= '1;
		zero       <= 1'b1;
		pc_branch  <= '1;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		store_load_pairs();
		hold_after_load();
		random_ops();
		// Flush the last operation through the register
		repeat (3) issue_op('0, '0, '0);
		$display("Test completed successfully");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Comparison
	//////////////////////////////////////////////////////////////////////

	// Inputs and register outputs are both settled on the falling edge
	always @(negedge clk)
	begin : compare
		dram_idx_t idx;
		if (!arst_n)
		begin
			check({30'b0, mem_wb.wb}, 32'h0, "mem_wb.wb in reset");
			check(mem_wb.read_data, 32'h0, "mem_wb.read_data in reset");
			check(mem_wb.alu_result, 32'h0, "mem_wb.alu_result in reset");
			check({27'b0, mem_wb.dest_reg}, 32'h0, "mem_wb.dest_reg in reset");
		end
		else
		begin
			// Registered result of the previous cycle's operation
			check({30'b0, mem_wb.wb}, {30'b0, exp_wb.wb}, "mem_wb.wb");
			check(mem_wb.read_data, exp_wb.read_data, "mem_wb.read_data");
			check(mem_wb.alu_result, exp_wb.alu_result, "mem_wb.alu_result");
			check({27'b0, mem_wb.dest_reg}, {27'b0, exp_wb.dest_reg}, "mem_wb.dest_reg");

			// Branch outputs are combinational
			check({31'b0, pc_src}, {31'b0, expected_branch(mem_ctrl, zero)}, "pc_src");
			check(pc_branch_out, pc_branch, "pc_branch_out");

			// Read sees the old word on a same-cycle write
			idx = alu_result[IDX_W-1:0];
			if (mem_ctrl.mem_read)
			begin
				ref_rd = ref_mem[idx];
			end
			if (mem_ctrl.mem_write)
			begin
				ref_mem[idx] = stored_word(store_data, mem_ctrl);
			end
			exp_wb.wb = wb_ctrl;
			exp_wb.read_data = expected_load(ref_rd, mem_ctrl);
			exp_wb.alu_result = alu_result;
			exp_wb.dest_reg = dest_reg;
		end
	end

endmodule

// ==== filelist.f ====
+incdir+.
cpu_types_pkg.sv
mem_ctrl_pkg.sv
data_ram.sv
mem_access.sv
mem_wb_stage.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== Makefile ====
TOP := tb_mem_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)

# Pass only if the simulation prints the pass message
run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
